//--- hw/op_engine_top.sv
`timescale 1ns/10ps

// operator state engine, top level.
module op_engine_top #(
	parameter int clk_div = 2 // system cycles per slot visit.
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wr,
	input  logic [op_pkg::slot_w-1:0]      wr_slot,
	input  op_pkg::reg_sel_e               wr_sel,
	input  logic [op_pkg::wr_data_w-1:0]   wr_data,
	output logic                           out_valid,
	output logic [op_pkg::slot_w-1:0]      out_slot,
	output logic [op_pkg::out_phase_w-1:0] out_phase,
	output logic [op_pkg::att_w-1:0]       out_att,
	output op_pkg::eg_state_e              out_eg
);
	import op_pkg::*;

	logic               en;
	logic [slot_w-1:0]  cur_slot, nxt_slot;
	logic [state_w-1:0] ram_q, ram_wdata;
	logic [phase_w-1:0] phase_inc;
	logic [rate_w-1:0]  ar, dr;
	logic [sus_w-1:0]   sus;
	logic               key;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing and storage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	op_slot_timer #(.clk_div(clk_div)) i_timer (
		.clk, .rst, .en, .cur_slot, .nxt_slot
	);

	op_state_ram i_ram (
		.clk, .en,
		.rd_slot (nxt_slot), // fetch one ahead.
		.wr_slot (cur_slot),
		.wdata   (ram_wdata),
		.q       (ram_q)
	);

	op_regs i_regs (
		.clk, .rst, .wr, .wr_slot, .wr_sel, .wr_data,
		.rd_slot (cur_slot), // settings of the slot being stored.
		.phase_inc, .ar, .dr, .sus, .key
	);

	// next state and visit outputs.
	op_update i_update (
		.clk, .rst, .en,
		.slot  (cur_slot),
		.q     (ram_q),
		.phase_inc, .ar, .dr, .sus, .key,
		.wdata (ram_wdata),
		.out_valid, .out_slot, .out_phase, .out_att, .out_eg
	);

endmodule

//--- hw/op_pkg.sv
package op_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// slot sequencing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int num_slots = 32; // operator slots per frame.
	localparam int slot_w    = 5;  // slot index.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operator word fields.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int phase_w     = 20; // phase accumulator.
	localparam int att_w       = 10; // attenuation, 1023 is silent.
	localparam int out_phase_w = 10; // top phase bits reported per visit.
	localparam int eg_w        = 3;  // envelope state code.
	localparam int state_w     = phase_w + att_w + eg_w; // ram word, 33 bits.

	localparam logic [att_w-1:0] att_silent = '1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host settings.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int rate_w    = 6;  // attack and decay rates.
	localparam int sus_w     = 4;  // sustain level vs top att bits.
	localparam int wr_data_w = 20; // wide enough for a phase increment.

	// off is all ones so a preloaded word is an idle, silent slot.
	typedef enum logic [eg_w-1:0] {
		eg_attack  = 3'd0,
		eg_decay   = 3'd1,
		eg_sustain = 3'd2,
		eg_release = 3'd3,
		eg_off     = 3'b111
	} eg_state_e;

	// sel_rates data: {ar, dr, sus} in bits 15:0.
	// sel_key data: bit 0 only.
	typedef enum logic [1:0] {
		sel_phase_inc = 2'd0,
		sel_rates     = 2'd1,
		sel_key       = 2'd2
	} reg_sel_e;

endpackage

//--- hw/op_regs.sv
`timescale 1ns/10ps

// per-slot host settings. written by select, read by slot.
module op_regs (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wr,
	input  logic [op_pkg::slot_w-1:0]    wr_slot,
	input  op_pkg::reg_sel_e             wr_sel,
	input  logic [op_pkg::wr_data_w-1:0] wr_data,
	input  logic [op_pkg::slot_w-1:0]    rd_slot,
	output logic [op_pkg::phase_w-1:0]   phase_inc,
	output logic [op_pkg::rate_w-1:0]    ar,
	output logic [op_pkg::rate_w-1:0]    dr,
	output logic [op_pkg::sus_w-1:0]     sus,
	output logic                         key
);
	import op_pkg::*;

	// field positions inside the sel_rates word.
	localparam int sus_lsb = 0;
	localparam int dr_lsb  = sus_lsb + sus_w; // bit 4.
	localparam int ar_lsb  = dr_lsb + rate_w; // bit 10.

	logic [phase_w-1:0] inc_r [num_slots];
	logic [rate_w-1:0]  ar_r  [num_slots];
	logic [rate_w-1:0]  dr_r  [num_slots];
	logic [sus_w-1:0]   sus_r [num_slots];
	logic               key_r [num_slots];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host write port. takes effect from the next clock.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_slots; i++) begin
				inc_r[i] <= '0;
				ar_r[i]  <= '0;
				dr_r[i]  <= '0;
				sus_r[i] <= '0;
				key_r[i] <= 1'b0; // all keys off.
			end
		end else if (wr) begin
			case (wr_sel)
				sel_phase_inc: begin
					inc_r[wr_slot] <= wr_data[phase_w-1:0];
				end
				sel_rates: begin
					ar_r[wr_slot]  <= wr_data[ar_lsb +: rate_w];
					dr_r[wr_slot]  <= wr_data[dr_lsb +: rate_w];
					sus_r[wr_slot] <= wr_data[sus_lsb +: sus_w];
				end
				sel_key: begin
					key_r[wr_slot] <= wr_data[0];
				end
				default: ; // unused select, ignored.
			endcase
		end
	end

	// read side, combinational for the update logic.
	always_comb begin
		phase_inc = inc_r[rd_slot];
		ar        = ar_r[rd_slot];
		dr        = dr_r[rd_slot];
		sus       = sus_r[rd_slot];
		key       = key_r[rd_slot];
	end

endmodule

//--- hw/op_slot_timer.sv
`timescale 1ns/10ps

// visit sequencer. en every clk_div cycles, slot count 0..31.
module op_slot_timer #(
	parameter int clk_div = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	output logic                      en,
	output logic [op_pkg::slot_w-1:0] cur_slot,
	output logic [op_pkg::slot_w-1:0] nxt_slot
);
	import op_pkg::*;

	localparam int div_w = $clog2(clk_div);
	localparam logic [div_w-1:0] div_last = div_w'(clk_div - 1);
	localparam logic [slot_w-1:0] slot_last = slot_w'(num_slots - 1);

	logic [div_w-1:0] div_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// divider. en is registered, so it stays low one cycle past reset.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			en      <= 1'b0;
		end else begin
			div_cnt <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;
			en      <= (div_cnt == div_last); // one cycle pulse.
		end
	end

	// slot being written back on this en.
	always_ff @(posedge clk) begin
		if (rst) begin
			cur_slot <= '0;
		end else if (en) begin
			cur_slot <= (cur_slot == slot_last) ? '0 : cur_slot + 1'b1;
		end
	end

	assign nxt_slot = (cur_slot == slot_last) ? '0 : cur_slot + 1'b1; // ram read address.

endmodule

//--- hw/op_state_ram.sv
`timescale 1ns/10ps

// slot state memory. one read, one write per enable.
module op_state_ram (
	input  logic                        clk,
	input  logic                        en,
	input  logic [op_pkg::slot_w-1:0]   rd_slot,
	input  logic [op_pkg::slot_w-1:0]   wr_slot,
	input  logic [op_pkg::state_w-1:0]  wdata,
	output logic [op_pkg::state_w-1:0]  q
);
	import op_pkg::*;

	logic [state_w-1:0] mem [num_slots]; // phase, att, eg per slot.

	// power-up contents: every slot silent and off.
	initial begin
		for (int i = 0; i < num_slots; i++) begin
			mem[i] = '1;
		end
		q = '1; // first write-back sees the preload too.
	end

	// fetch next slot while the current one is stored.
	// addresses always differ by one, so no collision.
	always @(posedge clk) begin
		if (en) begin
			q <= mem[rd_slot];
			mem[wr_slot] <= wdata;
		end
	end

endmodule

//--- hw/op_update.sv
`timescale 1ns/10ps

// phase and envelope step for one slot, plus registered visit outputs.
module op_update (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           en,
	input  logic [op_pkg::slot_w-1:0]      slot,
	input  logic [op_pkg::state_w-1:0]     q,
	input  logic [op_pkg::phase_w-1:0]     phase_inc,
	input  logic [op_pkg::rate_w-1:0]      ar,
	input  logic [op_pkg::rate_w-1:0]      dr,
	input  logic [op_pkg::sus_w-1:0]       sus,
	input  logic                           key,
	output logic [op_pkg::state_w-1:0]     wdata,
	output logic                           out_valid,
	output logic [op_pkg::slot_w-1:0]      out_slot,
	output logic [op_pkg::out_phase_w-1:0] out_phase,
	output logic [op_pkg::att_w-1:0]       out_att,
	output op_pkg::eg_state_e              out_eg
);
	import op_pkg::*;

	logic [phase_w-1:0] old_phase, new_phase;
	logic [att_w-1:0]   old_att, new_att;
	logic [att_w:0]     att_up;   // one spare bit for saturation.
	logic               key_hit;  // key-on from off or release.
	eg_state_e          old_eg, mid_eg, new_eg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word layout: {phase, att, eg}.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign old_phase = q[state_w-1 -: phase_w];
	assign old_att   = q[eg_w +: att_w];
	assign old_eg    = eg_state_e'(q[eg_w-1:0]);

	assign new_phase = old_phase + phase_inc; // wraps at 20 bits.
	assign att_up    = {1'b0, old_att} + (att_w + 1)'(dr);

	always_comb begin
		key_hit = key && (old_eg == eg_off || old_eg == eg_release);

		// key off sends any live slot to release.
		mid_eg = old_eg;
		if (!key && old_eg != eg_off) begin
			mid_eg = eg_release;
		end

		new_att = old_att;
		new_eg  = mid_eg;
		if (key_hit) begin
			new_eg = eg_attack; // att held on the key-on visit.
		end else begin
			case (mid_eg)
				eg_attack: begin
					if (old_att <= att_w'(ar)) begin
						new_att = '0;
						new_eg  = eg_decay; // bottom reached.
					end else begin
						new_att = old_att - att_w'(ar);
					end
				end
				eg_decay: begin
					new_att = att_up[att_w] ? att_silent : att_up[att_w-1:0];
					if (new_att[att_w-1 -: sus_w] >= sus) begin
						new_eg = eg_sustain;
					end
				end
				eg_release: begin
					new_att = att_up[att_w] ? att_silent : att_up[att_w-1:0];
					if (new_att == att_silent) begin
						new_eg = eg_off; // fully decayed.
					end
				end
				default: ; // sustain and off hold.
			endcase
		end
	end

	assign wdata = {new_phase, new_att, new_eg}; // back to ram on en.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// visit outputs, one cycle after en.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= en;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			out_slot  <= slot;
			out_phase <= new_phase[phase_w-1 -: out_phase_w]; // top bits.
			out_att   <= new_att;
			out_eg    <= new_eg;
		end
	end

endmodule

//--- list.f
hw/op_pkg.sv
hw/op_state_ram.sv
hw/op_slot_timer.sv
hw/op_regs.sv
hw/op_update.sv
hw/op_engine_top.sv
tests/op_engine_assertions.sv
tests/op_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the operator engine testbench with Verilator.
# Exits nonzero when the build, the run or the testbench fails.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

verilator --binary --assert --top-module op_engine_tb -f list.f \
	-Mdir obj_dir -o op_engine_sim >"$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/op_engine_sim >"$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$sim_log"; then
	exit 1
fi
exit 0

//--- tests/op_engine_assertions.sv
`timescale 1ns/10ps

// visit timing checks, bound into the update block.
module op_engine_assertions (
	input logic                      clk,
	input logic                      rst,
	input logic                      en,        // from the slot timer.
	input logic                      out_valid,
	input logic [op_pkg::slot_w-1:0] out_slot
);
	import op_pkg::*;

	logic [slot_w-1:0] last_slot; // slot of the previous pulse.
	logic              seen;      // a pulse since reset.

	always_ff @(posedge clk) begin
		if (rst) begin
			seen <= 1'b0;
		end else if (out_valid) begin
			seen      <= 1'b1;
			last_slot <= out_slot;
		end
	end

	a_valid_after_en: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(en)) else $error("out_valid is not en delayed by one cycle");

	a_en_single: assert property (@(posedge clk) disable iff (rst)
		en |=> !en) else $error("en high on two cycles in a row");

	// slots come round in order, 31 back to 0.
	a_slot_step: assert property (@(posedge clk) disable iff (rst)
		(out_valid && seen) |-> out_slot == slot_w'(last_slot + 1'b1))
		else $error("out_slot did not step by one between pulses");

endmodule

bind op_update op_engine_assertions i_assertions (.clk, .rst, .en, .out_valid, .out_slot);

//--- tests/op_engine_tb.sv
`timescale 1ns/10ps

module op_engine_tb;
	import op_pkg::*;

	localparam int clk_div      = 2;
	localparam int frame_cycles = num_slots * clk_div; // one pass over all slots.
	localparam int valid_limit  = 10 * clk_div;        // max gap between visits.
	localparam int eg_limit     = 300 * frame_cycles;  // slowest envelope phase.
	localparam int run_limit    = 1000000;
	localparam logic [wr_data_w-1:0] key_on  = wr_data_w'(1);
	localparam logic [wr_data_w-1:0] key_off = wr_data_w'(0);

	// one slot's host settings as the tb wrote them.
	typedef struct packed {
		logic [phase_w-1:0] inc;
		logic [rate_w-1:0]  ar;
		logic [rate_w-1:0]  dr;
		logic [sus_w-1:0]   sus;
		logic               key;
	} settings_t;

	logic                   clk, rst, wr;
	logic [slot_w-1:0]      wr_slot;
	reg_sel_e               wr_sel;
	logic [wr_data_w-1:0]   wr_data;
	logic                   out_valid;
	logic [slot_w-1:0]      out_slot;
	logic [out_phase_w-1:0] out_phase;
	logic [att_w-1:0]       out_att;
	eg_state_e              out_eg;

	settings_t          set_now  [num_slots]; // after the last clock.
	settings_t          set_used [num_slots]; // before it, seen by that visit.
	logic [phase_w-1:0] sh_phase [num_slots];
	int                 sh_att   [num_slots];
	eg_state_e          sh_eg    [num_slots];

	int                err_cnt     = 0;
	int                timeout_cnt = 0;
	int                check_cnt   = 0;
	int                visit_cnt   = 0;
	bit                run_done    = 1'b0;
	logic [slot_w-1:0] exp_slot    = '0; // next slot due on out_valid.

	op_engine_top #(.clk_div(clk_div)) i_dut (
		.clk, .rst, .wr, .wr_slot, .wr_sel, .wr_data,
		.out_valid, .out_slot, .out_phase, .out_att, .out_eg
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// settings mirror, one copy per side of each clock edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		set_used = set_now;
		if (rst) begin
			for (int i = 0; i < num_slots; i++) begin
				set_now[i] = '0; // keys off.
			end
		end else if (wr) begin
			case (wr_sel)
				sel_phase_inc: set_now[wr_slot].inc = wr_data[phase_w-1:0];
				sel_rates: begin
					set_now[wr_slot].ar  = wr_data[15:10]; // {ar, dr, sus}.
					set_now[wr_slot].dr  = wr_data[9:4];
					set_now[wr_slot].sus = wr_data[3:0];
				end
				sel_key: set_now[wr_slot].key = wr_data[0];
				default: ;
			endcase
		end
	end

	// one visit of slot s under settings cfg, applied to the shadow.
	function automatic void ref_visit(input int s, input settings_t cfg);
		int        att;
		eg_state_e eg;
		att = sh_att[s];
		eg  = sh_eg[s];
		sh_phase[s] = sh_phase[s] + cfg.inc; // wraps at 20 bits.
		if (cfg.key && (eg == eg_off || eg == eg_release)) begin
			eg = eg_attack; // att kept on the key-on visit.
		end else begin
			if (!cfg.key && eg != eg_off) begin
				eg = eg_release;
			end
			case (eg)
				eg_attack: begin
					att = att - int'(cfg.ar);
					if (att <= 0) begin
						att = 0;
						eg  = eg_decay;
					end
				end
				eg_decay: begin
					att = (att + int'(cfg.dr) > 1023) ? 1023 : att + int'(cfg.dr);
					if (att / 64 >= int'(cfg.sus)) eg = eg_sustain; // top 4 bits.
				end
				eg_release: begin
					att = (att + int'(cfg.dr) > 1023) ? 1023 : att + int'(cfg.dr);
					if (att == 1023) eg = eg_off;
				end
				default: ; // sustain, off hold.
			endcase
		end
		sh_att[s] = att;
		sh_eg[s]  = eg;
	endfunction

	function automatic logic [wr_data_w-1:0] pack_rates(input int ar, input int dr, input int sus);
		return wr_data_w'({rate_w'(ar), rate_w'(dr), sus_w'(sus)});
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks, one per output field.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic compare_slot(input logic [slot_w-1:0] got, input logic [slot_w-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0d ns: out_slot is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic compare_phase(input logic [out_phase_w-1:0] got,
		input logic [out_phase_w-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0d ns: slot %0d out_phase is %h, expected %h",
				$time, exp_slot, got, exp);
		end
	endtask

	task automatic compare_att(input logic [att_w-1:0] got, input logic [att_w-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0d ns: slot %0d out_att is %0d, expected %0d",
				$time, exp_slot, got, exp);
		end
	endtask

	task automatic compare_eg(input eg_state_e got, input eg_state_e exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0d ns: slot %0d out_eg is %s, expected %s",
				$time, exp_slot, got.name(), exp.name());
		end
	endtask

	task automatic wait_valid(output bit seen);
		int n;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < valid_limit) begin
			@(negedge clk);
			n++;
			seen = out_valid;
		end
	endtask

	// checker, one pass per out_valid pulse.
	initial begin
		bit got_one;
		while (!run_done) begin
			wait_valid(got_one);
			if (!got_one) begin
				$display("Timeout: no out_valid within %0d cycles", valid_limit);
				timeout_cnt++;
				run_done = 1'b1;
			end else begin
				ref_visit(int'(exp_slot), set_used[exp_slot]);
				compare_slot(out_slot, exp_slot);
				compare_phase(out_phase, sh_phase[exp_slot][phase_w-1 -: out_phase_w]);
				compare_att(out_att, att_w'(sh_att[exp_slot]));
				compare_eg(out_eg, sh_eg[exp_slot]);
				exp_slot = exp_slot + 1'b1; // wraps at 32.
				visit_cnt++;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic write_reg(input int slot, input reg_sel_e sel, input logic [wr_data_w-1:0] data);
		@(negedge clk);
		wr      = 1'b1;
		wr_slot = slot_w'(slot);
		wr_sel  = sel;
		wr_data = data;
		@(negedge clk);
		wr = 1'b0; // single-cycle strobe.
	endtask

	task automatic random_write();
		int       slot;
		reg_sel_e sel;
		slot = int'($urandom % num_slots);
		case ($urandom % 3)
			0: sel = sel_phase_inc;
			1: sel = sel_rates;
			default: sel = sel_key;
		endcase
		write_reg(slot, sel, wr_data_w'($urandom));
	endtask

	task automatic wait_visits(input int n);
		int target;
		int cyc;
		target = visit_cnt + n;
		cyc    = 0;
		while (visit_cnt < target && cyc < 2 * n * clk_div + valid_limit) begin
			@(negedge clk);
			cyc++;
		end
		if (visit_cnt < target) begin
			$display("Timeout: %0d visits did not complete", n);
			timeout_cnt++;
			run_done = 1'b1;
		end
	endtask

	task automatic wait_eg(input int slot, input eg_state_e state);
		int cyc;
		bit hit;
		cyc = 0;
		hit = 1'b0;
		while (!hit && cyc < eg_limit) begin
			@(negedge clk);
			cyc++;
			hit = out_valid && out_slot == slot_w'(slot) && out_eg == state;
		end
		if (!hit) begin
			$display("Timeout: slot %0d never reported state %s", slot, state.name());
			timeout_cnt++;
			run_done = 1'b1;
		end
	endtask

	initial begin
		void'($urandom(2));
		rst     = 1'b1;
		wr      = 1'b0;
		wr_slot = '0;
		wr_sel  = sel_phase_inc;
		wr_data = '0;
		for (int i = 0; i < num_slots; i++) begin
			sh_phase[i] = '1; // ram preload.
			sh_att[i]   = 1023;
			sh_eg[i]    = eg_off;
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;

		wait_visits(num_slots + 1); // idle frame, all silent.

		for (int i = 0; i < 8; i++) begin
			write_reg(int'($urandom % num_slots), sel_phase_inc, wr_data_w'($urandom));
		end
		wait_visits(3 * num_slots);

		// attack, decay, sustain on slot 3.
		write_reg(3, sel_rates, pack_rates(40, 20, 8));
		write_reg(3, sel_key, key_on);
		wait_eg(3, eg_attack);
		wait_eg(3, eg_decay);
		wait_eg(3, eg_sustain);
		wait_visits(2 * num_slots);

		// key off from attack (7), sustain (3), decay (9).
		write_reg(7, sel_rates, pack_rates(20, 5, 12));
		write_reg(7, sel_key, key_on);
		wait_eg(7, eg_attack);
		wait_visits(3 * num_slots);
		write_reg(7, sel_key, key_off);
		wait_eg(7, eg_release);
		write_reg(3, sel_key, key_off);
		wait_eg(3, eg_release);
		write_reg(9, sel_rates, pack_rates(63, 4, 14));
		write_reg(9, sel_key, key_on);
		wait_eg(9, eg_decay);
		write_reg(9, sel_key, key_off);
		wait_eg(9, eg_release);
		write_reg(9, sel_key, key_on); // re-key mid release.
		wait_eg(9, eg_attack);
		wait_eg(9, eg_decay);
		wait_eg(7, eg_off);
		wait_eg(3, eg_off);

		for (int i = 0; i < 200; i++) begin
			random_write();
			repeat ($urandom % 8) @(negedge clk);
		end
		wait_visits(4 * num_slots);
		run_done = 1'b1;
	end

	// end of run, the only exit.
	initial begin
		int n;
		n = 0;
		while (!run_done && n < run_limit) begin
			@(negedge clk);
			n++;
		end
		if (!run_done) begin
			$display("Timeout: run did not finish within %0d cycles", run_limit);
			timeout_cnt++;
		end
		$display("checks %0d, mismatches %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
